// File: fe_top.f
+incdir+design
design/fe_queue_pkg.sv
design/fe_cmd_pkg.sv
design/fe_pc_gen.sv
design/fe_imem.sv
design/fe_controller.sv
design/fe_top.sv
verification/fe_top_chk.sv
verification/fe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fe_top testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f fe_top.f --top-module fe_tb \
  -o fe_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/fe_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: imem.hex
// Instruction ROM, one 32-bit word per line starting at address 0
// Word 4 is beq x1,x2,+16 and word 22 is bne x3,x4,-32, the rest are addi
00008093
00108093
00208093
00308093
00208863
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
fe4190e3
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093

// File: verification/fe_tb.sv
// Must run from the project root to find imem.hex and sends commands only while ready is held low
`timescale 1ns/1ps
`default_nettype none
`include "fe_settings.svh"

module fe_tb;

  import fe_cmd_pkg::*;
  import fe_queue_pkg::*;

  localparam int timeout_lp = 200;
  localparam int rom_aw_lp  = $clog2(`FE_IMEM_WORDS);
  localparam int bht_els_lp = 1 << `FE_BHT_IDX_WIDTH;

  typedef struct packed {
    fe_cmd_s cmd;
    int      n_msgs;
    int      ready_lvl;
  } step_s;

  logic                       clk_i;
  logic                       reset_i;
  fe_cmd_s                    cmd;
  logic                       cmd_v;
  logic                       cmd_yumi;
  fe_queue_s                  q_msg;
  logic                       q_v;
  logic                       q_ready;
  step_s                      steps [$];
  fe_queue_s                  exp_q [$];
  logic [`FE_INSTR_WIDTH-1:0] rom_model [`FE_IMEM_WORDS];
  logic [1:0]                 bht_model [bht_els_lp];
  integer                     seed;
  int                         step_idx;
  int                         msg_idx;
  logic                       init_seen;

  fe_top dut0
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(cmd)
     ,.fe_cmd_v_i(cmd_v)
     ,.fe_cmd_yumi_o(cmd_yumi)
     ,.fe_queue_o(q_msg)
     ,.fe_queue_v_o(q_v)
     ,.fe_queue_ready_i(q_ready)
     );

  initial
    begin
      clk_i = 1'b0;
      forever
        #10 clk_i = ~clk_i;
    end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_queue(input fe_queue_s exp_msg);
    if (q_msg !== exp_msg)
      stop_on_error($sformatf("ERR fe_queue_o step %0d msg %0d expected %h got %h",
                              step_idx, msg_idx, exp_msg, q_msg));
  endtask

  task automatic check_yumi(input logic exp_yumi);
    if (cmd_yumi !== exp_yumi)
      stop_on_error($sformatf("ERR fe_cmd_yumi_o step %0d expected %h got %h",
                              step_idx, exp_yumi, cmd_yumi));
  endtask

  task automatic check_valid(input logic exp_v);
    if (q_v !== exp_v)
      stop_on_error($sformatf("ERR fe_queue_v_o step %0d expected %h got %h",
                              step_idx, exp_v, q_v));
  endtask

  function automatic fe_cmd_s redirect_cmd(input logic [`FE_VADDR_WIDTH-1:0] pc,
                                           input fe_subop_e subop, input fe_reason_e reason,
                                           input logic [`FE_BHT_IDX_WIDTH-1:0] idx);
    fe_cmd_s c;
    c = '0;
    c.opcode = e_op_pc_redirect;
    c.vaddr = pc;
    c.operands.redirect.subop = subop;
    c.operands.redirect.reason = reason;
    c.operands.redirect.meta.bht_idx = idx;
    return c;
  endfunction

  function automatic fe_cmd_s attaboy_cmd(input logic [`FE_BHT_IDX_WIDTH-1:0] idx,
                                          input logic taken);
    fe_cmd_s c;
    c = '0;
    c.opcode = e_op_attaboy;
    c.operands.attaboy.taken = taken;
    c.operands.attaboy.meta.bht_idx = idx;
    return c;
  endfunction

  function automatic step_s make_step(input fe_cmd_s c, input int n, input int lvl);
    step_s s;
    s.cmd = c;
    s.n_msgs = n;
    s.ready_lvl = lvl;
    return s;
  endfunction

  // Branch at 0x10 uses index 4, branch at 0x58 uses index 6
  task automatic load_steps();
    steps.push_back(make_step(redirect_cmd(32'h08, e_subop_resume, e_not_a_branch, 4'h0), 6, 0));
    steps.push_back(make_step(attaboy_cmd(4'h4, 1'b1), 0, 0));
    steps.push_back(make_step(attaboy_cmd(4'h4, 1'b1), 0, 0));
    steps.push_back(make_step(redirect_cmd(32'h0c, e_subop_resume, e_not_a_branch, 4'h0), 4, 1));
    steps.push_back(make_step(redirect_cmd(32'h14, e_subop_branch_mispredict,
                                           e_pred_taken_wrong, 4'h4), 3, 1));
    steps.push_back(make_step(redirect_cmd(32'h14, e_subop_branch_mispredict,
                                           e_pred_taken_wrong, 4'h4), 2, 0));
    steps.push_back(make_step(redirect_cmd(32'h04, e_subop_resume, e_not_a_branch, 4'h0), 5, 2));
    steps.push_back(make_step(attaboy_cmd(4'h6, 1'b1), 0, 0));
    steps.push_back(make_step(attaboy_cmd(4'h6, 1'b1), 0, 0));
    steps.push_back(make_step(redirect_cmd(32'h4c, e_subop_resume, e_not_a_branch, 4'h0), 14, 2));
    steps.push_back(make_step(redirect_cmd(32'h40, e_subop_branch_mispredict,
                                           e_not_a_branch, 4'h6), 3, 1));
    steps.push_back(make_step(attaboy_cmd(4'h6, 1'b0), 0, 0));
    steps.push_back(make_step(redirect_cmd(32'h50, e_subop_resume, e_not_a_branch, 4'h0), 5, 2));
    steps.push_back(make_step(redirect_cmd(32'h80, e_subop_resume, e_not_a_branch, 4'h0), 1, 0));
    steps.push_back(make_step(redirect_cmd(32'h06, e_subop_resume, e_not_a_branch, 4'h0), 1, 1));
    steps.push_back(make_step(redirect_cmd(32'h7c, e_subop_resume, e_not_a_branch, 4'h0), 2, 2));
    steps.push_back(make_step(redirect_cmd(32'h00, e_subop_branch_mispredict,
                                           e_pred_ntaken_wrong, 4'h4), 6, 1));
  endtask

  // B-type immediate scattered over bits 31:25 and 11:7
  function automatic logic [`FE_VADDR_WIDTH-1:0] branch_offset(
      input logic [`FE_INSTR_WIDTH-1:0] instr);
    logic [12:0] imm;
    imm[12]   = instr[31];
    imm[11]   = instr[7];
    imm[10:5] = instr[30:25];
    imm[4:1]  = instr[11:8];
    imm[0]    = 1'b0;
    return {{(`FE_VADDR_WIDTH-13){imm[12]}}, imm};
  endfunction

  // Saturating 2-bit counter step per training rule
  function automatic void train_model(input fe_cmd_s c);
    logic [`FE_BHT_IDX_WIDTH-1:0] idx;
    logic                         up;
    logic                         v;
    v = 1'b0;
    up = 1'b0;
    idx = '0;
    if (c.opcode == e_op_attaboy)
      begin
        v = 1'b1;
        idx = c.operands.attaboy.meta.bht_idx;
        up = c.operands.attaboy.taken;
      end
    else if (c.operands.redirect.subop == e_subop_branch_mispredict
             && c.operands.redirect.reason != e_not_a_branch)
      begin
        v = 1'b1;
        idx = c.operands.redirect.meta.bht_idx;
        up = (c.operands.redirect.reason == e_pred_ntaken_wrong);
      end
    if (v && up && bht_model[idx] != 2'b11)
      bht_model[idx] = bht_model[idx] + 2'b01;
    else if (v && !up && bht_model[idx] != 2'b00)
      bht_model[idx] = bht_model[idx] - 2'b01;
  endfunction

  // Architectural pc walk with the predicted-taken branches followed
  function automatic void build_expected(input logic [`FE_VADDR_WIDTH-1:0] start_pc,
                                         input int n);
    logic [`FE_VADDR_WIDTH-1:0] pc;
    logic [`FE_INSTR_WIDTH-1:0] instr;
    logic [rom_aw_lp-1:0]       word;
    logic                       is_br;
    logic                       taken;
    fe_queue_s                  m;
    pc = start_pc;
    exp_q.delete();
    for (int i = 0; i < n; i++)
      begin
        m = '0;
        instr = '0;
        taken = 1'b0;
        if (pc[1:0] != 2'b00)
          begin
            m.msg_type = e_fe_exception;
            m.msg.exception.vaddr = pc;
            m.msg.exception.code = e_instr_misaligned;
          end
        else if ((pc >> 2) >= `FE_IMEM_WORDS)
          begin
            m.msg_type = e_fe_exception;
            m.msg.exception.vaddr = pc;
            m.msg.exception.code = e_instr_access_fault;
          end
        else
          begin
            word = pc[2 +: rom_aw_lp];
            instr = rom_model[word];
            is_br = (instr[6:0] == `FE_BRANCH_OPCODE);
            taken = is_br & bht_model[pc[2 +: `FE_BHT_IDX_WIDTH]][1];
            m.msg_type = e_fe_fetch;
            m.msg.fetch.pc = pc;
            m.msg.fetch.instr = instr;
            m.msg.fetch.meta.bht_idx = pc[2 +: `FE_BHT_IDX_WIDTH];
            m.msg.fetch.meta.pred_taken = taken;
            m.msg.fetch.meta.is_br = is_br;
          end
        exp_q.push_back(m);
        pc = taken ? pc + branch_offset(instr) : pc + 4;
      end
  endfunction

  task automatic send_cmd(input fe_cmd_s c);
    int waited;
    waited = 0;
    @(posedge clk_i);
    cmd <= c;
    cmd_v <= 1'b1;
    @(negedge clk_i);
    if (init_seen)
      check_yumi(1'b1);
    else
      begin
        // BHT clear still running
        check_yumi(1'b0);
        while (!cmd_yumi)
          begin
            waited++;
            if (waited > timeout_lp)
              stop_on_error("timed out waiting for fe_cmd_yumi_o after the BHT clear");
            @(negedge clk_i);
          end
        init_seen = 1'b1;
      end
    @(posedge clk_i);
    cmd_v <= 1'b0;
  endtask

  task automatic collect_msgs(input int lvl);
    int        waited;
    logic      last_exc;
    fe_queue_s exp_msg;
    waited = 0;
    last_exc = 1'b0;
    msg_idx = 0;
    while (exp_q.size() != 0)
      begin
        @(posedge clk_i);
        q_ready <= (($random(seed) & 3) >= lvl);
        @(negedge clk_i);
        if (q_v)
          begin
            exp_msg = exp_q.pop_front();
            check_queue(exp_msg);
            last_exc = (exp_msg.msg_type == e_fe_exception);
            msg_idx++;
            waited = 0;
          end
        else
          begin
            waited++;
            if (waited > timeout_lp)
              stop_on_error($sformatf("timed out waiting for queue message %0d in step %0d",
                                      msg_idx, step_idx));
          end
      end
    // Nothing may follow an exception even with ready held high
    if (last_exc)
      repeat (8)
        begin
          @(posedge clk_i);
          q_ready <= 1'b1;
          @(negedge clk_i);
          check_valid(1'b0);
        end
    @(posedge clk_i);
    q_ready <= 1'b0;
  endtask

  initial
    begin
      seed = 32'h9d0a;
      reset_i = 1'b1;
      cmd = '0;
      cmd_v = 1'b0;
      q_ready = 1'b1;
      init_seen = 1'b0;
      step_idx = 0;
      msg_idx = 0;
      bht_model = '{default: 2'b01};
      $readmemh("imem.hex", rom_model);
      load_steps();
      repeat (16) @(posedge clk_i);
      reset_i <= 1'b0;
      q_ready <= 1'b0;
      foreach (steps[i])
        begin
          step_idx = i;
          send_cmd(steps[i].cmd);
          train_model(steps[i].cmd);
          if (steps[i].cmd.opcode == e_op_pc_redirect)
            begin
              build_expected(steps[i].cmd.vaddr, steps[i].n_msgs);
              collect_msgs(steps[i].ready_lvl);
            end
        end
      $display("Simulation passed");
      $finish;
    end

endmodule

`default_nettype wire

// File: verification/fe_top_chk.sv
// Checks only the queue and command handshakes and a quiet queue while reset is held
`timescale 1ns/1ps
`default_nettype none

module fe_top_chk
  (input  logic   clk_i
   , input logic  reset_i
   , input logic  cmd_v_i
   , input logic  cmd_yumi_i
   , input logic  queue_v_i
   , input logic  queue_ready_i
   );

  // A message is only offered while the consumer can take it
  queue_v_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    queue_v_i |-> queue_ready_i)
    else $error("fe_queue_v_o high while fe_queue_ready_i is low");

  cmd_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_i |-> cmd_v_i)
    else $error("fe_cmd_yumi_o high without fe_cmd_v_i");

  // Pipeline valids settle after the first reset edge
  queue_quiet_in_reset: assert property (@(posedge clk_i)
    reset_i && $past(reset_i) |-> !queue_v_i)
    else $error("fe_queue_v_o high during reset");

endmodule

bind fe_top fe_top_chk chk0
  (.clk_i(clk_i)
   ,.reset_i(reset_i)
   ,.cmd_v_i(fe_cmd_v_i)
   ,.cmd_yumi_i(fe_cmd_yumi_o)
   ,.queue_v_i(fe_queue_v_o)
   ,.queue_ready_i(fe_queue_ready_i)
   );

`default_nettype wire

// File: design/fe_top.sv
// No commands are taken until the BHT clear ends and fe_queue_v_o is only raised while ready is high
`timescale 1ns/1ps
`default_nettype none
`include "fe_settings.svh"

module fe_top
  (input  logic                      clk_i
   , input  logic                    reset_i
   , input  fe_cmd_pkg::fe_cmd_s     fe_cmd_i
   , input  logic                    fe_cmd_v_i
   , output logic                    fe_cmd_yumi_o
   , output fe_queue_pkg::fe_queue_s fe_queue_o
   , output logic                    fe_queue_v_o
   , input  logic                    fe_queue_ready_i
   );

  import fe_cmd_pkg::*;
  import fe_queue_pkg::*;

  logic                       init_done;
  logic                       ovr;
  fe_redirect_s               redirect;
  fe_bht_update_s             bht_update;
  logic                       next_pc_yumi;
  logic [`FE_VADDR_WIDTH-1:0] next_pc;
  logic [`FE_INSTR_WIDTH-1:0] fetch_instr;
  logic                       fetch_v;
  logic [`FE_VADDR_WIDTH-1:0] fetch_pc;
  fe_br_meta_s                fetch_meta;
  fe_fault_s                  fault;

  fe_pc_gen pc_gen
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.init_done_o(init_done)
     ,.redirect_i(redirect)
     ,.bht_update_i(bht_update)
     ,.next_pc_yumi_i(next_pc_yumi)
     ,.next_pc_o(next_pc)
     ,.fetch_instr_i(fetch_instr)
     ,.fetch_v_i(fetch_v)
     ,.fetch_pc_o(fetch_pc)
     ,.fetch_meta_o(fetch_meta)
     ,.ovr_o(ovr)
     );

  // Stands in for the icache
  fe_imem imem
    (.clk_i(clk_i)
     ,.addr_i(next_pc)
     ,.read_i(next_pc_yumi)
     ,.instr_o(fetch_instr)
     ,.fault_o(fault)
     );

  fe_controller controller
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fe_cmd_i(fe_cmd_i)
     ,.fe_cmd_v_i(fe_cmd_v_i)
     ,.fe_cmd_yumi_o(fe_cmd_yumi_o)
     ,.fe_queue_o(fe_queue_o)
     ,.fe_queue_v_o(fe_queue_v_o)
     ,.fe_queue_ready_i(fe_queue_ready_i)
     ,.init_done_i(init_done)
     ,.ovr_i(ovr)
     ,.fetch_pc_i(fetch_pc)
     ,.fetch_meta_i(fetch_meta)
     ,.fetch_instr_i(fetch_instr)
     ,.fault_i(fault)
     ,.redirect_o(redirect)
     ,.bht_update_o(bht_update)
     ,.next_pc_yumi_o(next_pc_yumi)
     ,.fetch_v_o(fetch_v)
     );

endmodule

`default_nettype wire

// File: design/fe_controller.sv
// Redirect commands win over everything else in the cycle and drop any message in IF2 at that time
`timescale 1ns/1ps
`default_nettype none
`include "fe_settings.svh"

module fe_controller
  (input  logic                         clk_i
   , input  logic                       reset_i
   , input  fe_cmd_pkg::fe_cmd_s        fe_cmd_i
   , input  logic                       fe_cmd_v_i
   , output logic                       fe_cmd_yumi_o
   , output fe_queue_pkg::fe_queue_s    fe_queue_o
   , output logic                       fe_queue_v_o
   , input  logic                       fe_queue_ready_i
   , input  logic                       init_done_i
   , input  logic                       ovr_i
   , input  logic [`FE_VADDR_WIDTH-1:0] fetch_pc_i
   , input  fe_queue_pkg::fe_br_meta_s  fetch_meta_i
   , input  logic [`FE_INSTR_WIDTH-1:0] fetch_instr_i
   , input  fe_queue_pkg::fe_fault_s    fault_i
   , output fe_cmd_pkg::fe_redirect_s   redirect_o
   , output fe_cmd_pkg::fe_bht_update_s bht_update_o
   , output logic                       next_pc_yumi_o
   , output logic                       fetch_v_o
   );

  import fe_cmd_pkg::*;
  import fe_queue_pkg::*;

  typedef enum logic [1:0] {e_wait, e_run, e_stall} state_e;

  state_e                     state_r;
  state_e                     state_n;
  fe_redirect_ops_s           rops;
  fe_attaboy_ops_s            aops;
  logic                       cmd_redirect_v;
  logic                       cmd_attaboy_v;
  logic                       br_miss_v;
  fe_br_meta_s                cmd_meta;
  logic [`FE_VADDR_WIDTH-1:0] resume_pc_r;
  fe_br_meta_s                resume_meta_r;
  logic                       v_if1_r;
  logic                       v_if2_r;
  logic                       exc_v;
  logic                       queue_miss;
  logic                       exc_sent;
  logic                       poison;

  assign fe_cmd_yumi_o = fe_cmd_v_i & init_done_i;

  assign rops           = fe_cmd_i.operands.redirect;
  assign aops           = fe_cmd_i.operands.attaboy;
  assign cmd_redirect_v = fe_cmd_yumi_o & (fe_cmd_i.opcode == e_op_pc_redirect);
  assign cmd_attaboy_v  = fe_cmd_yumi_o & (fe_cmd_i.opcode == e_op_attaboy);
  assign br_miss_v      = cmd_redirect_v & (rops.subop == e_subop_branch_mispredict);

  always_comb
    if (cmd_attaboy_v)
      bht_update_o = '{v: 1'b1, idx: aops.meta.bht_idx, up: aops.taken};
    else
      bht_update_o = '{v: br_miss_v & (rops.reason != e_not_a_branch),
                       idx: rops.meta.bht_idx,
                       up: (rops.reason == e_pred_ntaken_wrong)};

  // A new pc only needs its own table index
  assign cmd_meta = '{bht_idx: fe_cmd_i.vaddr[2 +: `FE_BHT_IDX_WIDTH], pred_taken: 1'b0,
                      is_br: 1'b0};

  assign exc_v        = fault_i.misaligned | fault_i.access;
  assign queue_miss   = v_if2_r & ~fe_queue_ready_i;
  assign fe_queue_v_o = v_if2_r & fe_queue_ready_i & ~cmd_redirect_v;
  assign fetch_v_o    = fe_queue_v_o & ~exc_v;
  assign exc_sent     = fe_queue_v_o & exc_v;
  assign poison       = ovr_i | queue_miss | exc_sent | cmd_redirect_v;

  // Restart point, the dropped IF2 item on back-pressure
  always_ff @(posedge clk_i)
    if (cmd_redirect_v)
      begin
        resume_pc_r   <= fe_cmd_i.vaddr;
        resume_meta_r <= cmd_meta;
      end
    else if (queue_miss)
      begin
        resume_pc_r   <= fetch_pc_i;
        resume_meta_r <= fetch_meta_i;
      end

  always_comb
    if (cmd_redirect_v)
      redirect_o = '{v: 1'b1, pc: fe_cmd_i.vaddr, meta: cmd_meta};
    else
      redirect_o = '{v: (state_r == e_stall) & next_pc_yumi_o, pc: resume_pc_r,
                     meta: resume_meta_r};

  always_comb
    case (state_r)
      e_wait : state_n = cmd_redirect_v ? e_run : e_wait;
      e_run  : state_n = cmd_redirect_v ? e_run
                       : queue_miss     ? e_stall
                       : exc_sent       ? e_wait
                       : e_run;
      e_stall: state_n = (cmd_redirect_v | fe_queue_ready_i) ? e_run : e_stall;
      default: state_n = e_wait;
    endcase

  assign next_pc_yumi_o = (state_n == e_run);

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        state_r <= e_wait;
        v_if1_r <= 1'b0;
        v_if2_r <= 1'b0;
      end
    else
      begin
        state_r <= state_n;
        v_if1_r <= next_pc_yumi_o;
        v_if2_r <= v_if1_r & ~poison;
      end

  // Misaligned is reported ahead of an access fault
  always_comb
    begin
      fe_queue_o = '0;
      if (exc_v)
        begin
          fe_queue_o.msg_type            = e_fe_exception;
          fe_queue_o.msg.exception.vaddr = fetch_pc_i;
          fe_queue_o.msg.exception.code  = fault_i.misaligned ? e_instr_misaligned
                                                              : e_instr_access_fault;
        end
      else
        begin
          fe_queue_o.msg_type        = e_fe_fetch;
          fe_queue_o.msg.fetch.pc    = fetch_pc_i;
          fe_queue_o.msg.fetch.instr = fetch_instr_i;
          fe_queue_o.msg.fetch.meta  = fetch_meta_i;
        end
    end

endmodule

`default_nettype wire

// File: design/fe_imem.sv
// Power-of-two ROM at address zero loaded from imem.hex in the run directory with data two edges after read
`timescale 1ns/1ps
`default_nettype none
`include "fe_settings.svh"

module fe_imem
  (input  logic                         clk_i
   , input  logic [`FE_VADDR_WIDTH-1:0] addr_i
   , input  logic                       read_i
   , output logic [`FE_INSTR_WIDTH-1:0] instr_o
   , output fe_queue_pkg::fe_fault_s    fault_o
   );

  localparam int idx_width_lp = $clog2(`FE_IMEM_WORDS);

  logic [`FE_INSTR_WIDTH-1:0] mem_r [`FE_IMEM_WORDS];
  logic [`FE_VADDR_WIDTH-1:0] addr_r;

  initial
    $readmemh("imem.hex", mem_r);

  // Address held while the item sits in IF1
  always_ff @(posedge clk_i)
    if (read_i)
      addr_r <= addr_i;

  // Word and faults land together in IF2
  always_ff @(posedge clk_i)
    begin
      instr_o            <= mem_r[addr_r[2 +: idx_width_lp]];
      fault_o.misaligned <= (addr_r[1:0] != 2'b00);
      fault_o.access     <= (addr_r[`FE_VADDR_WIDTH-1:2] >= `FE_IMEM_WORDS);
    end

endmodule

`default_nettype wire

// File: design/fe_pc_gen.sv
// BHT is unusable for 2**FE_BHT_IDX_WIDTH cycles after reset and predictions are read live in IF2
`timescale 1ns/1ps
`default_nettype none
`include "fe_settings.svh"

module fe_pc_gen
  (input  logic                         clk_i
   , input  logic                       reset_i
   , output logic                       init_done_o
   , input  fe_cmd_pkg::fe_redirect_s   redirect_i
   , input  fe_cmd_pkg::fe_bht_update_s bht_update_i
   , input  logic                       next_pc_yumi_i
   , output logic [`FE_VADDR_WIDTH-1:0] next_pc_o
   , input  logic [`FE_INSTR_WIDTH-1:0] fetch_instr_i
   , input  logic                       fetch_v_i
   , output logic [`FE_VADDR_WIDTH-1:0] fetch_pc_o
   , output fe_queue_pkg::fe_br_meta_s  fetch_meta_o
   , output logic                       ovr_o
   );

  import fe_queue_pkg::*;

  localparam int bht_els_lp = 1 << `FE_BHT_IDX_WIDTH;
  localparam logic [`FE_VADDR_WIDTH-1:0] instr_bytes_lp = 4;

  logic [`FE_BHT_IDX_WIDTH-1:0] init_cnt_r;
  logic                         init_done_r;
  logic [1:0]                   bht_r [bht_els_lp];
  logic [1:0]                   bht_cnt;
  logic [1:0]                   bht_cnt_n;
  logic [`FE_VADDR_WIDTH-1:0]   pc_if1_r;
  logic [`FE_VADDR_WIDTH-1:0]   pc_if2_r;
  fe_br_meta_s                  meta_if1_n;
  fe_br_meta_s                  meta_if1_r;
  fe_br_meta_s                  meta_if2_r;
  logic                         is_br;
  logic [`FE_VADDR_WIDTH-1:0]   br_imm;

  // Walk every entry once after reset
  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        init_cnt_r  <= '0;
        init_done_r <= 1'b0;
      end
    else if (!init_done_r)
      begin
        init_cnt_r  <= init_cnt_r + 1'b1;
        init_done_r <= &init_cnt_r;
      end

  assign init_done_o = init_done_r;

  // 2-bit saturating counters
  assign bht_cnt = bht_r[bht_update_i.idx];
  always_comb
    if (bht_update_i.up)
      bht_cnt_n = (bht_cnt == 2'b11) ? bht_cnt : bht_cnt + 2'b01;
    else
      bht_cnt_n = (bht_cnt == 2'b00) ? bht_cnt : bht_cnt - 2'b01;

  // Cleared to weakly not taken
  always_ff @(posedge clk_i)
    if (!init_done_r)
      bht_r[init_cnt_r] <= 2'b01;
    else if (bht_update_i.v)
      bht_r[bht_update_i.idx] <= bht_cnt_n;

  // IF2 decode, B-type immediate
  assign is_br  = (fetch_instr_i[6:0] == `FE_BRANCH_OPCODE);
  assign br_imm = {{(`FE_VADDR_WIDTH-12){fetch_instr_i[31]}}, fetch_instr_i[7],
                   fetch_instr_i[30:25], fetch_instr_i[11:8], 1'b0};

  assign fetch_pc_o = pc_if2_r;
  always_comb
    begin
      fetch_meta_o            = meta_if2_r;
      fetch_meta_o.is_br      = is_br;
      fetch_meta_o.pred_taken = is_br & bht_r[meta_if2_r.bht_idx][1];
    end

  // Only an instruction actually handed to the queue may steer fetch
  assign ovr_o = fetch_v_i & fetch_meta_o.pred_taken;

  always_comb
    if (redirect_i.v)
      next_pc_o = redirect_i.pc;
    else if (ovr_o)
      next_pc_o = pc_if2_r + br_imm;
    else
      next_pc_o = pc_if1_r + instr_bytes_lp;

  // Prediction and branch flag are filled in once the word is seen in IF2
  always_comb
    if (redirect_i.v)
      meta_if1_n = redirect_i.meta;
    else
      meta_if1_n = '{bht_idx: next_pc_o[2 +: `FE_BHT_IDX_WIDTH], pred_taken: 1'b0, is_br: 1'b0};

  // IF2 always advances in step with the ROM output register
  always_ff @(posedge clk_i)
    begin
      if (next_pc_yumi_i)
        begin
          pc_if1_r   <= next_pc_o;
          meta_if1_r <= meta_if1_n;
        end
      pc_if2_r   <= pc_if1_r;
      meta_if2_r <= meta_if1_r;
    end

endmodule

`default_nettype wire

// File: design/fe_cmd_pkg.sv
// Needs fe_queue_pkg compiled first and the operand word is only meaningful together with the opcode
`default_nettype none
`include "fe_settings.svh"

package fe_cmd_pkg;

  typedef enum logic [1:0] {
    e_op_pc_redirect = 2'd0,
    e_op_attaboy     = 2'd1
  } fe_opcode_e;

  typedef enum logic {
    e_subop_resume            = 1'b0,
    e_subop_branch_mispredict = 1'b1
  } fe_subop_e;

  typedef enum logic [1:0] {
    e_pred_taken_wrong  = 2'd0,
    e_pred_ntaken_wrong = 2'd1,
    e_not_a_branch      = 2'd2
  } fe_reason_e;

  typedef struct packed {
    fe_subop_e                 subop;
    fe_reason_e                reason;
    fe_queue_pkg::fe_br_meta_s meta;
  } fe_redirect_ops_s;

  // Padded to the size of the redirect operands
  typedef struct packed {
    logic                                         taken;
    fe_queue_pkg::fe_br_meta_s                    meta;
    logic [$bits(fe_subop_e)+$bits(fe_reason_e)-2:0] pad;
  } fe_attaboy_ops_s;

  typedef union packed {
    fe_redirect_ops_s redirect;
    fe_attaboy_ops_s  attaboy;
  } fe_operands_u;

  typedef struct packed {
    fe_opcode_e                 opcode;
    logic [`FE_VADDR_WIDTH-1:0] vaddr;
    fe_operands_u               operands;
  } fe_cmd_s;

  // Restart request from the controller to the pc generator
  typedef struct packed {
    logic                       v;
    logic [`FE_VADDR_WIDTH-1:0] pc;
    fe_queue_pkg::fe_br_meta_s  meta;
  } fe_redirect_s;

  // One counter step, up increments and down decrements
  typedef struct packed {
    logic                         v;
    logic [`FE_BHT_IDX_WIDTH-1:0] idx;
    logic                         up;
  } fe_bht_update_s;

endpackage

`default_nettype wire

// File: design/fe_queue_pkg.sv
// Fetch and exception views share one 70-bit word so any field change must keep both sizes equal
`default_nettype none
`include "fe_settings.svh"

package fe_queue_pkg;

  // Branch metadata sent along with every fetched instruction
  typedef struct packed {
    logic [`FE_BHT_IDX_WIDTH-1:0] bht_idx;
    logic                         pred_taken;
    logic                         is_br;
  } fe_br_meta_s;

  typedef enum logic [1:0] {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1
  } fe_exc_code_e;

  typedef enum logic {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef struct packed {
    logic [`FE_VADDR_WIDTH-1:0] pc;
    logic [`FE_INSTR_WIDTH-1:0] instr;
    fe_br_meta_s                meta;
  } fe_fetch_msg_s;

  // Padded up to the width of the fetch view
  typedef struct packed {
    logic [`FE_VADDR_WIDTH-1:0]                                   vaddr;
    fe_exc_code_e                                                 code;
    logic [`FE_INSTR_WIDTH+$bits(fe_br_meta_s)-$bits(fe_exc_code_e)-1:0] pad;
  } fe_exc_msg_s;

  typedef union packed {
    fe_fetch_msg_s fetch;
    fe_exc_msg_s   exception;
  } fe_msg_u;

  typedef struct packed {
    fe_msg_type_e msg_type;
    fe_msg_u      msg;
  } fe_queue_s;

  typedef struct packed {
    logic misaligned;
    logic access;
  } fe_fault_s;

endpackage

`default_nettype wire

// File: design/fe_settings.svh
// Assumes an RV32 fetch path with the ROM mapped from address zero and the BHT indexed from pc bit 2
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// Virtual address width in bits
`define FE_VADDR_WIDTH 32

// Instruction width in bits
`define FE_INSTR_WIDTH 32

// Instruction ROM depth in 32-bit words
// Must be a power of two
`define FE_IMEM_WORDS 32

// BHT index bits, taken from pc[2 +: FE_BHT_IDX_WIDTH]
`define FE_BHT_IDX_WIDTH 4

// Major opcode of the conditional branches (BEQ, BNE, BLT, BGE, BLTU, BGEU)
`define FE_BRANCH_OPCODE 7'b1100011

`endif
